//--- hdl/capture_pkg.sv
`default_nettype none

package capture_pkg;

    localparam int SAMPLE_W   = 12;  // adc sample
    localparam int WORD_W     = 64;  // packed output word
    localparam int PRESAMP_W  = 15;
    localparam int COUNT_W    = 32;
    localparam int DOWNSAMP_W = 13;
    localparam int ERR_W      = 5;

    // drain wait in S_DONE, filler reads start below FILLER_START
    localparam int DONE_WAIT    = 20;
    localparam int FILLER_START = 6;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PRESAMP_FILLING,
        S_PRESAMP_FULL,
        S_TRIGGERED,
        S_DONE
    } capture_state_t;

    typedef struct packed {
        logic presamp_err;     // trigger before presamples filled
        logic downsample_err;  // presample and downsample both set
        logic clip_err;
        logic fifo_overflow;
        logic fifo_underflow;
    } error_flags_t;

    // named flags for setting, plain vector for clearing and OR-ing
    typedef union packed {
        error_flags_t          flag;
        logic [ERR_W-1:0]      vec;
    } error_stat_u;

endpackage

`default_nettype wire

//--- hdl/sample_if.sv
`timescale 1ns/1ns
`default_nettype none

interface sample_if;
    import capture_pkg::*;

    logic                wr;
    logic                rd;
    logic [SAMPLE_W-1:0] dout;       // valid the cycle after rd
    logic                empty;
    logic                overflow;   // registered pulses
    logic                underflow;

    modport fifo (input wr, input rd, output dout, output empty,
                  output overflow, output underflow);

    modport ctrl (output wr, output rd, input empty);

    modport mon (input dout, input rd, input overflow, input underflow);

endinterface

`default_nettype wire

//--- hdl/sample_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sample_fifo #(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic                              adc_sampleclk,
    input  logic                              reset,
    input  logic [capture_pkg::SAMPLE_W-1:0]  din_i,
    sample_if.fifo                            fifo
);
    import capture_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW-1:0] LAST    = AW'(FIFO_DEPTH - 1);
    localparam logic [AW:0]   DEPTH_C = (AW + 1)'(FIFO_DEPTH);

    logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         count;
    logic                full;
    logic                wr_ok;
    logic                rd_ok;

    assign full       = (count == DEPTH_C);
    assign fifo.empty = (count == '0);
    assign wr_ok      = fifo.wr && !full;        // sample lost when full
    assign rd_ok      = fifo.rd && !fifo.empty;

    always_ff @(posedge adc_sampleclk) begin
        if (wr_ok)
            mem[wr_ptr] <= din_i;
        if (rd_ok)
            fifo.dout <= mem[rd_ptr];
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            fifo.overflow  <= 1'b0;
            fifo.underflow <= 1'b0;
        end else begin
            if (wr_ok)
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            if (wr_ok && !rd_ok)
                count <= count + 1'b1;
            else if (rd_ok && !wr_ok)
                count <= count - 1'b1;
            fifo.overflow  <= fifo.wr && full;
            fifo.underflow <= fifo.rd && fifo.empty;
        end
    end

endmodule

`default_nettype wire

//--- hdl/capture_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module capture_fsm #(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic                                adc_sampleclk,
    input  logic                                reset,
    input  logic                                arm_i,
    input  logic                                capture_go_i,
    input  logic [capture_pkg::PRESAMP_W-1:0]   presample_i,
    input  logic [capture_pkg::COUNT_W-1:0]     max_samples_i,
    input  logic [capture_pkg::DOWNSAMP_W-1:0]  downsample_i,
    sample_if.ctrl                              fifo,
    output capture_pkg::capture_state_t         state_o,
    output logic                                pack_en_o,
    output logic                                filler_o,
    output logic                                armed_o,
    output logic                                capture_done_o,
    output logic                                arm_pulse_o,
    output logic                                presamp_err_o,
    output logic                                downsample_err_o
);
    import capture_pkg::*;

    capture_state_t        state;
    logic                  arm_r;
    logic                  go_r;
    logic                  go_r2;
    logic                  trig;
    logic [DOWNSAMP_W-1:0] ds_cnt;
    logic                  ds_strobe;
    logic [PRESAMP_W-1:0]  pres_cnt;
    logic [COUNT_W-1:0]    held;        // presamples actually kept in the fifo
    logic [COUNT_W-1:0]    sample_cnt;
    logic [4:0]            wait_cnt;
    logic [3:0]            fill_left;

    assign trig    = go_r && !go_r2;
    assign state_o = state;
    assign held    = (pres_cnt >= FIFO_DEPTH) ? COUNT_W'(FIFO_DEPTH) : COUNT_W'(pres_cnt);

    assign fifo.wr = ds_strobe && (state == S_PRESAMP_FILLING || state == S_PRESAMP_FULL ||
                                   state == S_TRIGGERED);
    assign pack_en_o = (state == S_TRIGGERED) || (state == S_DONE);
    // drop the oldest presample on every write once full
    assign fifo.rd  = (state == S_PRESAMP_FULL && fifo.wr) || (pack_en_o && !fifo.empty);
    assign filler_o = (state == S_DONE) && (wait_cnt < FILLER_START) && (fill_left != 4'd0);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r       <= 1'b0;
            arm_pulse_o <= 1'b0;
            go_r        <= 1'b0;
            go_r2       <= 1'b0;
        end else begin
            arm_r       <= arm_i;
            arm_pulse_o <= arm_i && !arm_r;
            go_r        <= capture_go_i;
            go_r2       <= go_r;
        end
    end

    // keeps one sample in downsample_i+1, realigned on the trigger
    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_o) begin
            ds_cnt    <= '0;
            ds_strobe <= 1'b0;
        end else if (ds_cnt == downsample_i || trig) begin
            ds_cnt    <= '0;
            ds_strobe <= 1'b1;
        end else begin
            ds_cnt    <= ds_cnt + 1'b1;
            ds_strobe <= 1'b0;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state            <= S_IDLE;
            armed_o          <= 1'b0;
            capture_done_o   <= 1'b0;
            pres_cnt         <= '0;
            sample_cnt       <= '0;
            wait_cnt         <= '0;
            fill_left        <= '0;
            presamp_err_o    <= 1'b0;
            downsample_err_o <= 1'b0;
        end else begin
            presamp_err_o    <= (state == S_PRESAMP_FILLING) && trig;
            downsample_err_o <= arm_pulse_o && (downsample_i != '0) && (presample_i != '0);
            if (arm_pulse_o) begin
                armed_o        <= 1'b1;
                capture_done_o <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    pres_cnt   <= '0;
                    sample_cnt <= '0;
                    wait_cnt   <= 5'(DONE_WAIT);
                    fill_left  <= 4'd0 - max_samples_i[3:0];  // zeros to close a group of 16
                    if (armed_o && presample_i != '0)
                        state <= S_PRESAMP_FILLING;
                    else if (armed_o && trig)
                        state <= S_TRIGGERED;
                end
                S_PRESAMP_FILLING: begin
                    if (trig) begin  // early trigger, flagged as presamp error
                        sample_cnt <= held + COUNT_W'(fifo.wr);
                        state      <= S_TRIGGERED;
                    end else if (fifo.wr) begin
                        pres_cnt <= pres_cnt + 1'b1;
                        if (pres_cnt + 1'b1 == presample_i)
                            state <= S_PRESAMP_FULL;
                    end
                end
                S_PRESAMP_FULL: begin
                    if (trig) begin
                        sample_cnt <= held;  // presamples count toward max_samples_i
                        state      <= S_TRIGGERED;
                    end
                end
                S_TRIGGERED: begin
                    if (fifo.wr) begin
                        sample_cnt <= sample_cnt + 1'b1;
                        if (sample_cnt + 1'b1 >= max_samples_i) begin
                            state          <= S_DONE;
                            armed_o        <= 1'b0;
                            capture_done_o <= 1'b1;
                        end
                    end
                end
                S_DONE: begin
                    // drain the fifo, then wait and send the filler zeros
                    if (fifo.empty && wait_cnt != '0)
                        wait_cnt <= wait_cnt - 1'b1;
                    if (filler_o)
                        fill_left <= fill_left - 1'b1;
                    if (fifo.empty && wait_cnt == '0 && fill_left == '0)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/word_packer.sv
`timescale 1ns/1ns
`default_nettype none

module word_packer (
    input  logic                            adc_sampleclk,
    input  logic                            reset,
    sample_if.mon                           fifo,
    input  capture_pkg::capture_state_t     state_i,
    input  logic                            pack_en_i,
    input  logic                            filler_i,
    output logic [capture_pkg::WORD_W-1:0]  word_o,
    output logic                            word_valid_o
);
    import capture_pkg::*;

    localparam int SHIFT_W = 6 * SAMPLE_W;

    logic [SHIFT_W-1:0]  shifter;
    logic [SHIFT_W-1:0]  shifted;
    logic [SAMPLE_W-1:0] sample;
    logic [1:0]          word_cnt;   // word within a group of 16 samples
    logic [2:0]          samp_cnt;
    logic                pack_q;     // dout holds a sample for packing
    logic                take;
    logic                word_end;
    logic                group_start;

    assign group_start = (word_cnt == 2'd0) && (samp_cnt == 3'd0);
    // filler zeros only until the current group of 16 is complete
    assign take     = (pack_q && !fifo.underflow) || (filler_i && !group_start);
    assign sample   = pack_q ? fifo.dout : '0;
    assign shifted  = {shifter[SHIFT_W-SAMPLE_W-1:0], sample};
    assign word_end = (word_cnt == 2'd0) ? (samp_cnt == 3'd5) : (samp_cnt == 3'd4);
    assign word_valid_o = take && word_end;

    // 6, 5, 5 samples per word, oldest bits at the top
    always_comb begin
        case (word_cnt)
            2'd0:    word_o = shifted[71:8];
            2'd1:    word_o = shifted[67:4];
            default: word_o = shifted[63:0];
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (take)
            shifter <= shifted;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || state_i == S_IDLE) begin
            pack_q   <= 1'b0;
            word_cnt <= '0;
            samp_cnt <= '0;
        end else begin
            pack_q <= fifo.rd && pack_en_i;
            if (take) begin
                if (word_end) begin
                    samp_cnt <= '0;
                    word_cnt <= (word_cnt == 2'd2) ? 2'd0 : word_cnt + 1'b1;
                end else begin
                    samp_cnt <= samp_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/error_status.sv
`timescale 1ns/1ns
`default_nettype none

module error_status (
    input  logic                          adc_sampleclk,
    input  logic                          reset,
    input  logic                          arm_pulse_i,
    input  logic                          clear_errors_i,
    sample_if.mon                         fifo,
    input  capture_pkg::capture_state_t   state_i,
    input  logic                          presamp_err_i,
    input  logic                          downsample_err_i,
    output logic                          error_flag_o,
    output capture_pkg::error_stat_u      error_stat_o,
    output capture_pkg::error_stat_u      first_error_stat_o,
    output capture_pkg::capture_state_t   first_error_state_o
);
    import capture_pkg::*;

    error_stat_u cause;
    logic        pack_rd_q;   // dout is a sample headed for the packer
    logic        clip;

    assign clip = pack_rd_q && !fifo.underflow &&
                  ((fifo.dout == '1) || (fifo.dout == '0));

    always_comb begin
        cause.flag.presamp_err    = presamp_err_i;
        cause.flag.downsample_err = downsample_err_i;
        cause.flag.clip_err       = clip;
        cause.flag.fifo_overflow  = fifo.overflow;
        cause.flag.fifo_underflow = fifo.underflow;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            pack_rd_q <= 1'b0;
        else
            pack_rd_q <= fifo.rd && (state_i == S_TRIGGERED || state_i == S_DONE);
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_i || clear_errors_i) begin
            error_flag_o        <= 1'b0;
            error_stat_o        <= '0;
            first_error_stat_o  <= '0;
            first_error_state_o <= S_IDLE;
        end else begin
            error_stat_o.vec <= error_stat_o.vec | cause.vec;  // sticky
            if (cause.vec != '0) begin
                error_flag_o <= 1'b1;
                if (!error_flag_o) begin
                    first_error_stat_o  <= cause;
                    first_error_state_o <= state_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/adc_capture_top.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture_top #(
    parameter int FIFO_DEPTH = 1024
) (
    input  logic                                adc_sampleclk,
    input  logic                                reset,
    input  logic [capture_pkg::SAMPLE_W-1:0]    adc_data_i,
    input  logic                                arm_i,
    input  logic                                capture_go_i,
    input  logic [capture_pkg::PRESAMP_W-1:0]   presample_i,
    input  logic [capture_pkg::COUNT_W-1:0]     max_samples_i,
    input  logic [capture_pkg::DOWNSAMP_W-1:0]  downsample_i,
    input  logic                                clear_errors_i,
    output logic [capture_pkg::WORD_W-1:0]      word_o,
    output logic                                word_valid_o,
    output logic                                armed_o,
    output logic                                capture_done_o,
    output logic [2:0]                          state_o,
    output logic                                error_flag_o,
    output logic [capture_pkg::ERR_W-1:0]       error_stat_o,
    output logic [capture_pkg::ERR_W-1:0]       first_error_stat_o,
    output logic [2:0]                          first_error_state_o
);
    import capture_pkg::*;

    capture_state_t state;
    logic           pack_en;
    logic           filler;
    logic           arm_pulse;
    logic           presamp_err;
    logic           downsample_err;

    sample_if fifo_bus ();

    assign state_o = state;

    capture_fsm #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fsm (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .capture_go_i     (capture_go_i),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .fifo             (fifo_bus.ctrl),
        .state_o          (state),
        .pack_en_o        (pack_en),
        .filler_o         (filler),
        .armed_o          (armed_o),
        .capture_done_o   (capture_done_o),
        .arm_pulse_o      (arm_pulse),
        .presamp_err_o    (presamp_err),
        .downsample_err_o (downsample_err)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .din_i         (adc_data_i),
        .fifo          (fifo_bus.fifo)
    );

    word_packer u_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .fifo          (fifo_bus.mon),
        .state_i       (state),
        .pack_en_i     (pack_en),
        .filler_i      (filler),
        .word_o        (word_o),
        .word_valid_o  (word_valid_o)
    );

    error_status u_err (
        .adc_sampleclk       (adc_sampleclk),
        .reset               (reset),
        .arm_pulse_i         (arm_pulse),
        .clear_errors_i      (clear_errors_i),
        .fifo                (fifo_bus.mon),
        .state_i             (state),
        .presamp_err_i       (presamp_err),
        .downsample_err_i    (downsample_err),
        .error_flag_o        (error_flag_o),
        .error_stat_o        (error_stat_o),
        .first_error_stat_o  (first_error_stat_o),
        .first_error_state_o (first_error_state_o)
    );

endmodule

`default_nettype wire

//--- verification/capture_sva.sv
`timescale 1ns/1ns
`default_nettype none

module capture_sva (
    input logic                             adc_sampleclk,
    input logic                             reset,
    input logic                             arm_i,
    input logic                             word_valid_i,
    input logic                             armed_i,
    input logic                             capture_done_i,
    input logic [2:0]                       state_i,
    input logic                             error_flag_i,
    input logic [capture_pkg::ERR_W-1:0]    error_stat_i,
    input logic [capture_pkg::ERR_W-1:0]    first_error_stat_i
);
    import capture_pkg::*;

    int unsigned fail_count = 0;  // summed up by the testbench

    // control outputs quiet in the cycle after every reset edge
    reset_quiet: assert property (@(posedge adc_sampleclk)
        reset |=> !armed_i && !capture_done_i && !word_valid_i && !error_flag_i &&
                  error_stat_i == '0 && first_error_stat_i == '0 && state_i == S_IDLE)
        else begin
            fail_count++;
            $error("control outputs active after reset");
        end

    idle_no_word: assert property (@(posedge adc_sampleclk) disable iff (reset)
        word_valid_i |-> state_i != S_IDLE)
        else begin
            fail_count++;
            $error("word_valid_o high in S_IDLE");
        end

    // arm edge seen two clocks before done drops
    done_until_arm: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $fell(capture_done_i) |-> $past(arm_i, 2) && !$past(arm_i, 3))
        else begin
            fail_count++;
            $error("capture_done_o fell without an arm edge");
        end

endmodule

bind adc_capture_top capture_sva sva0 (
    .adc_sampleclk      (adc_sampleclk),
    .reset              (reset),
    .arm_i              (arm_i),
    .word_valid_i       (word_valid_o),
    .armed_i            (armed_o),
    .capture_done_i     (capture_done_o),
    .state_i            (state_o),
    .error_flag_i       (error_flag_o),
    .error_stat_i       (error_stat_o),
    .first_error_stat_i (first_error_stat_o)
);

`default_nettype wire

//--- verification/tb_adc_capture.sv
`timescale 1ns/1ns
`default_nettype none

module tb_adc_capture;

    localparam int FIFO_DEPTH = 64;
    localparam int CLK_NS     = 10;
    localparam int LONG_PRE   = FIFO_DEPTH + 8;  // presamples beyond the fifo depth
    // samples x (downsample + 1) plus presample fill, test by test
    localparam int RUN_CYCLES = 37 + (50 + 20) + 20 * 3 + (16 + 40) + (24 + 4) * 2 +
                                (80 + LONG_PRE);
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 6 * 200;  // arm, drain and filler margin

    localparam logic [2:0] ST_IDLE            = 3'd0;
    localparam logic [2:0] ST_PRESAMP_FILLING = 3'd1;

    logic        adc_sampleclk = 1'b0;
    logic        reset;
    logic [11:0] adc_data_i;
    logic        arm_i;
    logic        capture_go_i;
    logic [14:0] presample_i;
    logic [31:0] max_samples_i;
    logic [12:0] downsample_i;
    logic        clear_errors_i;
    logic [63:0] word_o;
    logic        word_valid_o;
    logic        armed_o;
    logic        capture_done_o;
    logic [2:0]  state_o;
    logic        error_flag_o;
    logic [4:0]  error_stat_o;
    logic [4:0]  first_error_stat_o;
    logic [2:0]  first_error_state_o;

    logic [63:0] words[$];    // every word seen on word_valid_o
    logic [11:0] samples[$];  // words unpacked, oldest first
    logic [11:0] go_val;
    logic        jump_pending = 1'b0;
    int unsigned seed;

    adc_capture_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .adc_sampleclk       (adc_sampleclk),
        .reset               (reset),
        .adc_data_i          (adc_data_i),
        .arm_i               (arm_i),
        .capture_go_i        (capture_go_i),
        .presample_i         (presample_i),
        .max_samples_i       (max_samples_i),
        .downsample_i        (downsample_i),
        .clear_errors_i      (clear_errors_i),
        .word_o              (word_o),
        .word_valid_o        (word_valid_o),
        .armed_o             (armed_o),
        .capture_done_o      (capture_done_o),
        .state_o             (state_o),
        .error_flag_o        (error_flag_o),
        .error_stat_o        (error_stat_o),
        .first_error_stat_o  (first_error_stat_o),
        .first_error_state_o (first_error_state_o)
    );

    always #(CLK_NS / 2) adc_sampleclk = ~adc_sampleclk;

    // ramp moves on the falling edge, a pending jump puts it just below the wrap
    always @(negedge adc_sampleclk) begin
        if (jump_pending) begin
            adc_data_i   <= 12'hfe0;
            jump_pending = 1'b0;
        end else begin
            adc_data_i <= adc_data_i + 1'b1;
        end
    end

    always @(negedge adc_sampleclk)
        if (word_valid_o)
            words.push_back(word_o);

    task automatic expect_eq(input string test, input string what,
                             input longint expected, input longint actual);
        assert (expected == actual) else begin
            $display("ERROR %s: %s expected %0h actual %0h", test, what, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic arm_capture(input int pres, input int maxs, input int ds);
        @(negedge adc_sampleclk);
        words.delete();
        presample_i   <= 15'(pres);
        max_samples_i <= 32'(maxs);
        downsample_i  <= 13'(ds);
        arm_i         <= 1'b1;
        @(negedge adc_sampleclk);
        arm_i <= 1'b0;
        while (!armed_o)
            @(negedge adc_sampleclk);
    endtask

    // go_val is the ramp value sampled together with the go edge
    task automatic fire_trigger(output logic [11:0] sampled);
        @(negedge adc_sampleclk);
        capture_go_i <= 1'b1;
        @(posedge adc_sampleclk);
        sampled = adc_data_i;
        @(negedge adc_sampleclk);
        capture_go_i <= 1'b0;
    endtask

    task automatic wait_idle();
        while (!capture_done_o)
            @(negedge adc_sampleclk);
        while (state_o != ST_IDLE)   // fillers go out before idle
            @(negedge adc_sampleclk);
    endtask

    // three words hold 16 samples, first sample in the top bits
    task automatic check_ramp(input string test, input int maxs, input int step, input int first);
        logic [191:0] group;
        samples.delete();
        expect_eq(test, "word count", 3 * ((maxs + 15) / 16), words.size());
        for (int w = 0; w + 2 < words.size(); w += 3) begin
            group = {words[w], words[w + 1], words[w + 2]};
            for (int k = 0; k < 16; k++)
                samples.push_back(group[191 - 12 * k -: 12]);
        end
        for (int i = 0; i < samples.size(); i++) begin
            if (i < maxs)
                expect_eq(test, $sformatf("sample %0d", i), (first + i * step) % 4096, samples[i]);
            else
                expect_eq(test, $sformatf("filler %0d", i), 0, samples[i]);
        end
    endtask

    initial begin
        seed = 32'h2a6c912a;
        void'($urandom(seed));
        reset          <= 1'b1;
        adc_data_i     <= 12'(1 + $urandom % 1000);  // clear of 0x000 and 0xfff until the jump
        arm_i          <= 1'b0;
        capture_go_i   <= 1'b0;
        presample_i    <= '0;
        max_samples_i  <= '0;
        downsample_i   <= '0;
        clear_errors_i <= 1'b0;
        repeat (10) @(negedge adc_sampleclk);
        reset <= 1'b0;
        repeat (3) @(negedge adc_sampleclk);

        // go sampled, trigger registered, recording one cycle later
        arm_capture(0, 37, 0);
        fire_trigger(go_val);
        wait_idle();
        check_ramp("plain", 37, 1, go_val + 2);

        arm_capture(20, 50, 0);
        repeat (40) @(negedge adc_sampleclk);
        fire_trigger(go_val);
        wait_idle();
        check_ramp("presample", 50, 1, (go_val + 4096 + 2 - 20) % 4096);

        arm_capture(0, 20, 2);
        fire_trigger(go_val);
        wait_idle();
        check_ramp("downsample", 20, 3, go_val + 2);

        arm_capture(40, 16, 0);   // trigger long before 40 presamples
        repeat (5) @(negedge adc_sampleclk);
        fire_trigger(go_val);
        wait_idle();
        expect_eq("early trigger", "error_stat_o", 5'b10000, error_stat_o);
        expect_eq("early trigger", "error_flag_o", 1, error_flag_o);
        expect_eq("early trigger", "first_error_stat_o", 5'b10000, first_error_stat_o);
        @(negedge adc_sampleclk);
        clear_errors_i <= 1'b1;
        @(negedge adc_sampleclk);
        clear_errors_i <= 1'b0;
        expect_eq("clear", "error_stat_o", 0, error_stat_o);
        expect_eq("clear", "error_flag_o", 0, error_flag_o);
        expect_eq("clear", "first_error_stat_o", 0, first_error_stat_o);

        arm_capture(4, 24, 1);
        repeat (3) @(negedge adc_sampleclk);
        expect_eq("presample with downsample", "error_stat_o", 5'b01000, error_stat_o);
        @(posedge adc_sampleclk);
        jump_pending = 1'b1;
        repeat (16) @(negedge adc_sampleclk);
        fire_trigger(go_val);
        wait_idle();
        expect_eq("clip", "error_stat_o", 5'b01100, error_stat_o);
        expect_eq("clip", "first_error_stat_o", 5'b01000, first_error_stat_o);

        arm_capture(LONG_PRE, 80, 0);
        repeat (LONG_PRE + 12) @(negedge adc_sampleclk);
        fire_trigger(go_val);
        while (!capture_done_o)
            @(negedge adc_sampleclk);
        expect_eq("overflow", "armed_o", 0, armed_o);
        expect_eq("overflow", "fifo_overflow", 1, error_stat_o[1]);
        // the fifo fills up while the presamples are still being collected
        expect_eq("overflow", "first_error_stat_o", 5'b00010, first_error_stat_o);
        expect_eq("overflow", "first_error_state_o", ST_PRESAMP_FILLING, first_error_state_o);
        wait_idle();

        if (dut0.sva0.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("ERROR bound assertions: expected 0 failures, actual %0d",
                     dut0.sva0.fail_count);
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("the capture did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/capture_pkg.sv
hdl/sample_if.sv
hdl/sample_fifo.sv
hdl/capture_fsm.sv
hdl/word_packer.sv
hdl/error_status.sv
hdl/adc_capture_top.sv
verification/capture_sva.sv
verification/tb_adc_capture.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_adc_capture
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
LINT_TOP  ?= $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
